// File: beam_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths, counts and vector types for the beamforming combiner
// imported by every RTL and testbench file of the design
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package beam_pkg;

    // number of antenna channels combined into the single output stream
    localparam int num_channels = 4;

    // samples packed into one 128-bit word, lane 0 in the low bits
    localparam int num_lanes = 8;

    // one signed sample, real or imaginary
    localparam int sample_width = 16;

    // one signed weight part in Q1.7
    localparam int weight_width = 8;
    localparam int weight_frac_bits = 7;

    // a full sample by weight product needs the sum of both widths
    localparam int product_width = sample_width + weight_width;

    // width of a whole beat word on the stream
    localparam int word_width = num_lanes * sample_width;

    // cycles from an accepted beat to its output beat
    // decode 1, complex multiply 2, combine 1
    localparam int pipe_latency = 4;

    // one signed lane of a word
    typedef logic signed [sample_width-1:0] sample_t;

    // one signed weight part, range -1.0 up to 127/128
    typedef logic signed [weight_width-1:0] weight_t;

    // full precision product, before the Q1.7 scaling shift
    typedef logic signed [product_width-1:0] product_t;

    // packed word of num_lanes samples as it appears on the ports
    typedef logic [word_width-1:0] word_t;

endpackage

// File: lane_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// input register stage, splits each channel word into lanes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module lane_decode import beam_pkg::*; (
    input  logic    clock,
    input  logic    resetn,

    // one beat per channel, all channels aligned on one strobe
    input  logic    in_valid,
    input  logic    in_last,
    input  word_t   in_real [num_channels],
    input  word_t   in_imag [num_channels],

    // weights are sampled on the same edge as the beat they scale
    input  weight_t weight_real [num_channels],
    input  weight_t weight_imag [num_channels],

    output logic    dec_valid,
    output logic    dec_last,
    output sample_t dec_real [num_channels][num_lanes],
    output sample_t dec_imag [num_channels][num_lanes],
    output weight_t dec_weight_real [num_channels],
    output weight_t dec_weight_imag [num_channels]
);

    // strobes only, the payload below follows them
    always_ff @(posedge clock) begin
        if (!resetn) begin
            dec_valid <= 1'b0;
            dec_last  <= 1'b0;
        end else begin
            dec_valid <= in_valid;
            // in_last means nothing without in_valid, so mask it here once
            dec_last  <= in_valid && in_last;
        end
    end

    // samples and weights load together so each beat keeps its own weights
    // lanes hold their value between beats, which saves toggling downstream
    always_ff @(posedge clock) begin
        if (in_valid) begin
            for (int c = 0; c < num_channels; c++) begin
                dec_weight_real[c] <= weight_real[c];
                dec_weight_imag[c] <= weight_imag[c];
                for (int l = 0; l < num_lanes; l++) begin
                    // the slice is unsigned, the sample_t target makes it signed again
                    dec_real[c][l] <= in_real[c][l*sample_width +: sample_width];
                    dec_imag[c][l] <= in_imag[c][l*sample_width +: sample_width];
                end
            end
        end
    end

endmodule

// File: complex_weight_mult.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two stage complex multiply of one channel by its Q1.7 weight
// instantiated once per channel by the top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module complex_weight_mult import beam_pkg::*; (
    input  logic    clock,
    input  logic    resetn,

    input  logic    lane_valid,
    input  logic    lane_last,
    input  sample_t lane_real [num_lanes],
    input  sample_t lane_imag [num_lanes],
    input  weight_t weight_real,
    input  weight_t weight_imag,

    output logic    prod_valid,
    output logic    prod_last,
    output sample_t prod_real [num_lanes],
    output sample_t prod_imag [num_lanes]
);

    // stage one products, named by sample part then weight part
    product_t prod_rr [num_lanes];
    product_t prod_ii [num_lanes];
    product_t prod_ri [num_lanes];
    product_t prod_ir [num_lanes];

    // strobes between stage one and stage two
    logic     mid_valid;
    logic     mid_last;

    // scaled results before they drop to sample width
    product_t scaled_real [num_lanes];
    product_t scaled_imag [num_lanes];

    always_ff @(posedge clock) begin
        if (!resetn) begin
            mid_valid  <= 1'b0;
            mid_last   <= 1'b0;
            prod_valid <= 1'b0;
            prod_last  <= 1'b0;
        end else begin
            mid_valid  <= lane_valid;
            mid_last   <= lane_last;
            prod_valid <= mid_valid;
            prod_last  <= mid_last;
        end
    end

    // stage one, four signed 16 by 8 products per lane
    // both operands are signed so the product is sign extended to 24 bits
    always_ff @(posedge clock) begin
        if (lane_valid) begin
            for (int l = 0; l < num_lanes; l++) begin
                prod_rr[l] <= lane_real[l] * weight_real;
                prod_ii[l] <= lane_imag[l] * weight_imag;
                prod_ri[l] <= lane_real[l] * weight_imag;
                prod_ir[l] <= lane_imag[l] * weight_real;
            end
        end
    end

    // the true sum or difference can need 25 bits, but it is taken mod 2^24 here
    // only bits 22 down to 7 survive the shift and the wrap, and those bits
    // are the same in the wrapped and the exact value
    // the arithmetic shift gives floor division by 128
    always_comb begin
        for (int l = 0; l < num_lanes; l++) begin
            scaled_real[l] = (prod_rr[l] - prod_ii[l]) >>> weight_frac_bits;
            scaled_imag[l] = (prod_ri[l] + prod_ir[l]) >>> weight_frac_bits;
        end
    end

    // stage two, keep the low sample_width bits which wraps to 16 bits
    always_ff @(posedge clock) begin
        if (mid_valid) begin
            for (int l = 0; l < num_lanes; l++) begin
                prod_real[l] <= scaled_real[l][sample_width-1:0];
                prod_imag[l] <= scaled_imag[l][sample_width-1:0];
            end
        end
    end

endmodule

// File: channel_combiner.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lane by lane sum of the weighted channels, output register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module channel_combiner import beam_pkg::*; (
    input  logic    clock,
    input  logic    resetn,

    // strobes of channel 0 stand for all channels, they run in lockstep
    input  logic    prod_valid,
    input  logic    prod_last,
    input  sample_t prod_real [num_channels][num_lanes],
    input  sample_t prod_imag [num_channels][num_lanes],

    output logic    out_valid,
    output logic    out_last,
    output word_t   out_real,
    output word_t   out_imag
);

    // per lane totals over all channels
    sample_t sum_real [num_lanes];
    sample_t sum_imag [num_lanes];

    // the accumulator stays at sample width, so every add wraps to 16 bits
    // which matches the wrapped sum the output stream is defined by
    always_comb begin
        for (int l = 0; l < num_lanes; l++) begin
            sum_real[l] = '0;
            sum_imag[l] = '0;
            for (int c = 0; c < num_channels; c++) begin
                sum_real[l] = sum_real[l] + prod_real[c][l];
                sum_imag[l] = sum_imag[l] + prod_imag[c][l];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            out_valid <= prod_valid;
            out_last  <= prod_last;
        end
    end

    // pack the lanes back into words, lane 0 in the low bits as on the input
    always_ff @(posedge clock) begin
        if (prod_valid) begin
            for (int l = 0; l < num_lanes; l++) begin
                out_real[l*sample_width +: sample_width] <= sum_real[l];
                out_imag[l*sample_width +: sample_width] <= sum_imag[l];
            end
        end
    end

endmodule

// File: beamform_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// four channel complex beamforming combiner, top level
// takes one aligned beat per cycle and emits its sum four cycles later
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module beamform_top import beam_pkg::*; (
    input  logic    clock,
    input  logic    resetn,

    // no ready exists, a beat is taken on every edge with in_valid high
    input  logic    in_valid,
    input  logic    in_last,
    input  word_t   in_real [num_channels],
    input  word_t   in_imag [num_channels],
    input  weight_t weight_real [num_channels],
    input  weight_t weight_imag [num_channels],

    // one pulse per accepted beat, pipe_latency cycles after it
    output logic    out_valid,
    output logic    out_last,
    output word_t   out_real,
    output word_t   out_imag
);

    // decode stage outputs
    logic    dec_valid;
    logic    dec_last;
    sample_t dec_real [num_channels][num_lanes];
    sample_t dec_imag [num_channels][num_lanes];
    weight_t dec_weight_real [num_channels];
    weight_t dec_weight_imag [num_channels];

    // weighted channels, only channel 0 strobes go on to the combiner
    logic    prod_valid [num_channels];
    logic    prod_last [num_channels];
    sample_t prod_real [num_channels][num_lanes];
    sample_t prod_imag [num_channels][num_lanes];

    lane_decode u_lane_decode (
        .clock           (clock),
        .resetn          (resetn),
        .in_valid        (in_valid),
        .in_last         (in_last),
        .in_real         (in_real),
        .in_imag         (in_imag),
        .weight_real     (weight_real),
        .weight_imag     (weight_imag),
        .dec_valid       (dec_valid),
        .dec_last        (dec_last),
        .dec_real        (dec_real),
        .dec_imag        (dec_imag),
        .dec_weight_real (dec_weight_real),
        .dec_weight_imag (dec_weight_imag)
    );

    // one multiplier per channel, all fed from the same decode strobes
    for (genvar c = 0; c < num_channels; c++) begin : g_channel
        complex_weight_mult u_mult (
            .clock       (clock),
            .resetn      (resetn),
            .lane_valid  (dec_valid),
            .lane_last   (dec_last),
            .lane_real   (dec_real[c]),
            .lane_imag   (dec_imag[c]),
            .weight_real (dec_weight_real[c]),
            .weight_imag (dec_weight_imag[c]),
            .prod_valid  (prod_valid[c]),
            .prod_last   (prod_last[c]),
            .prod_real   (prod_real[c]),
            .prod_imag   (prod_imag[c])
        );
    end

    channel_combiner u_channel_combiner (
        .clock      (clock),
        .resetn     (resetn),
        .prod_valid (prod_valid[0]),
        .prod_last  (prod_last[0]),
        .prod_real  (prod_real),
        .prod_imag  (prod_imag),
        .out_valid  (out_valid),
        .out_last   (out_last),
        .out_real   (out_real),
        .out_imag   (out_imag)
    );

endmodule

// File: beamform_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// scoreboard for the combiner, predicts each beat and compares outputs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module beamform_checker import beam_pkg::*; (
    input  logic    clock,
    input  logic    resetn,
    input  logic    in_valid,
    input  logic    in_last,
    input  word_t   in_real [num_channels],
    input  word_t   in_imag [num_channels],
    input  weight_t weight_real [num_channels],
    input  weight_t weight_imag [num_channels],
    input  logic    out_valid,
    input  logic    out_last,
    input  word_t   out_real,
    input  word_t   out_imag,
    output int      pending,
    output int      checked,
    output int      error_count
);

    // expected beats in arrival order, each entry is {last, imag word, real word}
    logic [2*word_width:0] expected_q [$];

    // division by 2^frac_bits rounded toward minus infinity
    function automatic int floor_scale(input int p);
        int d;
        int q;
        d = 1 << weight_frac_bits;
        q = p / d;
        // integer division truncates toward zero, so negative remainders step down
        if (p < 0 && (p % d) != 0) q = q - 1;
        return q;
    endfunction

    // combined beat as {imag word, real word}
    function automatic logic [2*word_width-1:0] reference_beat(
        input word_t   xr [num_channels],
        input word_t   xi [num_channels],
        input weight_t wr [num_channels],
        input weight_t wi [num_channels]
    );
        sample_t sr;
        sample_t si;
        int      acc_re;
        int      acc_im;
        word_t   yr;
        word_t   yi;
        for (int l = 0; l < num_lanes; l++) begin
            acc_re = 0;
            acc_im = 0;
            for (int c = 0; c < num_channels; c++) begin
                sr = xr[c][l*sample_width +: sample_width];
                si = xi[c][l*sample_width +: sample_width];
                acc_re += floor_scale(int'(sr) * int'(wr[c]) - int'(si) * int'(wi[c]));
                acc_im += floor_scale(int'(sr) * int'(wi[c]) + int'(si) * int'(wr[c]));
            end
            // wrapping each channel term and then the sum keeps the same low 16 bits
            yr[l*sample_width +: sample_width] = acc_re[sample_width-1:0];
            yi[l*sample_width +: sample_width] = acc_im[sample_width-1:0];
        end
        return {yi, yr};
    endfunction

    initial begin
        pending = 0;
        checked = 0;
        error_count = 0;
    end

    // values seen at the edge are the ones the DUT registers on that same edge
    always @(posedge clock) begin : compare_and_queue
        logic [2*word_width:0] want;
        if (out_valid === 1'b1) begin
            if (expected_q.size() == 0) begin
                $display("output beat appeared with no input beat waiting for it");
                error_count++;
            end else begin
                want = expected_q.pop_front();
                checked++;
                if (out_real !== want[word_width-1:0]) begin
                    $display("Fail out_real expected %h got %h", want[word_width-1:0], out_real);
                    error_count++;
                end
                if (out_imag !== want[2*word_width-1:word_width]) begin
                    $display("Fail out_imag expected %h got %h",
                             want[2*word_width-1:word_width], out_imag);
                    error_count++;
                end
                if (out_last !== want[2*word_width]) begin
                    $display("Fail out_last expected %h got %h", want[2*word_width], out_last);
                    error_count++;
                end
            end
        end
        if (resetn === 1'b1 && in_valid === 1'b1) begin
            expected_q.push_back({in_last, reference_beat(in_real, in_imag,
                                                          weight_real, weight_imag)});
        end
        pending = expected_q.size();
    end

endmodule

// File: beamform_assert.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// timing properties of the combiner top level, bound into it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module beamform_assert import beam_pkg::*; (
    input logic clock,
    input logic resetn,
    input logic in_valid,
    input logic out_valid,
    input logic out_last
);

    // number of property failures so far
    int failures = 0;

    // a reset edge always leaves the output strobe low
    reset_quiet: assert property (@(posedge clock) !resetn |=> !out_valid)
        else begin
            $error("out_valid high after a reset edge");
            failures++;
        end

    // fixed pipeline, no stalls
    fixed_latency: assert property (@(posedge clock) disable iff (!resetn)
        in_valid |-> ##pipe_latency out_valid)
        else begin
            $error("accepted beat did not reach out_valid after pipe_latency cycles");
            failures++;
        end

    last_with_valid: assert property (@(posedge clock) disable iff (!resetn)
        out_last |-> out_valid)
        else begin
            $error("out_last high without out_valid");
            failures++;
        end

endmodule

bind beamform_top beamform_assert u_assert (
    .clock     (clock),
    .resetn    (resetn),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .out_last  (out_last)
);

// File: tb_beamform.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the beamforming combiner, five tests then a verdict
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_beamform import beam_pkg::*; ();

    logic    clock;
    logic    resetn;
    logic    in_valid;
    logic    in_last;
    word_t   in_real [num_channels];
    word_t   in_imag [num_channels];
    weight_t weight_real [num_channels];
    weight_t weight_imag [num_channels];
    logic    out_valid;
    logic    out_last;
    word_t   out_real;
    word_t   out_imag;
    int      pending;
    int      checked;
    int      error_count;

    // counts at the start of the running test
    int      beats_mark;
    int      errors_mark;
    int      tests_run;
    bit      timeout_seen;

    beamform_top dut0 (.*);
    beamform_checker checker0 (.*);

    always #5 clock = ~clock;

    function automatic int total_errors();
        return error_count + dut0.u_assert.failures;
    endfunction

    function automatic word_t random_word();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    // every lane sits at one of the two full scale extremes
    function automatic word_t full_scale_word();
        word_t w;
        for (int l = 0; l < num_lanes; l++) begin
            w[l*sample_width +: sample_width] = $urandom_range(1) ? 16'h7fff : 16'h8000;
        end
        return w;
    endfunction

    // mode 0 is channel 0 alone at 0x7f, mode 1 all random, mode 2 full scale at -128
    task automatic send_beat(input int mode, input bit last);
        @(posedge clock);
        in_valid <= 1'b1;
        in_last  <= last;
        for (int c = 0; c < num_channels; c++) begin
            in_real[c] <= (mode == 2) ? full_scale_word() : random_word();
            in_imag[c] <= (mode == 2) ? full_scale_word() : random_word();
            if (mode == 0) begin
                weight_real[c] <= (c == 0) ? 8'sh7f : 8'sh00;
                weight_imag[c] <= 8'sh00;
            end else if (mode == 1) begin
                weight_real[c] <= weight_t'($urandom);
                weight_imag[c] <= weight_t'($urandom);
            end else begin
                weight_real[c] <= 8'sh80;
                weight_imag[c] <= 8'sh80;
            end
        end
    endtask

    // in_last carries no meaning without in_valid and is left to toggle here
    task automatic idle_cycle();
        @(posedge clock);
        in_valid <= 1'b0;
        in_last  <= ($urandom_range(1) != 0);
    endtask

    // drops valid, lets the pipeline drain and prints the test line
    task automatic finish_test(input string name);
        int waited;
        idle_cycle();
        waited = 0;
        // the checker counts settle on the rising edge, so they are read on the falling one
        @(negedge clock);
        while (pending != 0 && waited < 64) begin
            @(negedge clock);
            waited++;
        end
        if (pending != 0) begin
            $display("timed out in test %s with %0d output beats still missing", name, pending);
            timeout_seen = 1'b1;
        end
        tests_run++;
        $display("test %0d %s done: %0d beats checked, %0d errors",
                 tests_run, name, checked - beats_mark, total_errors() - errors_mark);
        beats_mark  = checked;
        errors_mark = total_errors();
    endtask

    initial begin
        void'($urandom(53));
        clock    = 1'b0;
        resetn   = 1'b0;
        in_valid = 1'b0;
        in_last  = 1'b0;
        for (int c = 0; c < num_channels; c++) begin
            in_real[c]     = '0;
            in_imag[c]     = '0;
            weight_real[c] = '0;
            weight_imag[c] = '0;
        end
        beats_mark   = 0;
        errors_mark  = 0;
        tests_run    = 0;
        timeout_seen = 1'b0;
        // beats offered while resetn is low must never reach the output
        repeat (7) begin
            @(posedge clock);
            in_valid <= 1'b1;
            in_last  <= 1'b1;
        end
        @(posedge clock);
        in_valid <= 1'b0;
        in_last  <= 1'b0;
        resetn   <= 1'b1;
        // with no input the checker flags any output beat as unexpected
        repeat (12) idle_cycle();
        finish_test("reset");
        repeat (12) send_beat(0, 1'b0);
        finish_test("single channel");
        repeat (50) send_beat(1, 1'b0);
        finish_test("complex weights");
        repeat (16) send_beat(2, 1'b0);
        finish_test("overflow wrap");
        // ten beats back to back, then random gaps, frames of seven beats
        for (int b = 0; b < 30; b++) begin
            if (b >= 10 && $urandom_range(2) == 0) idle_cycle();
            send_beat(1, (b % 7 == 6) || (b == 29));
        end
        finish_test("streaming");
        $display("summary: %0d tests, %0d beats checked, %0d errors, timeout %0d",
                 tests_run, checked, total_errors(), timeout_seen);
        if (total_errors() == 0 && !timeout_seen) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
beam_pkg.sv
lane_decode.sv
complex_weight_mult.sv
channel_combiner.sv
beamform_top.sv
beamform_checker.sv
beamform_assert.sv
tb_beamform.sv

// File: Bender.yml
package:
  name: beamform_combiner

sources:
  - beam_pkg.sv
  - lane_decode.sv
  - complex_weight_mult.sv
  - channel_combiner.sv
  - beamform_top.sv
  - target: test
    files:
      - beamform_checker.sv
      - beamform_assert.sv
      - tb_beamform.sv
